// ==== Makefile ====
SRCS := $(wildcard hdl/*.sv tests/*.sv)

.PHONY: all run clean

all: obj_dir/Vosd_overlay_tb

obj_dir/Vosd_overlay_tb: flist.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps -j 0 \
		--top-module osd_overlay_tb -f flist.f -o Vosd_overlay_tb

run: obj_dir/Vosd_overlay_tb
	./obj_dir/Vosd_overlay_tb

clean:
	rm -rf obj_dir

// ==== flist.f ====
hdl/osd_pkg.sv
hdl/osd_cmd_decoder.sv
hdl/osd_char_buffer.sv
hdl/osd_glyph_renderer.sv
hdl/osd_video_mixer.sv
hdl/osd_overlay_top.sv
tests/osd_overlay_tb.sv

// ==== hdl/osd_char_buffer.sv ====
`timescale 1ns/1ps

module osd_char_buffer import osd_pkg::*; (
    input  logic                      clk_video,
    input  buf_wr_t                   buf_wr,
    input  logic [buf_addr_width-1:0] rd_addr,
    output logic [7:0]                rd_data
);

    // 16 rows of 32 characters, row major
    logic [7:0] mem [buf_depth];

    // ========================================
    // Write port
    // ========================================
    always_ff @(posedge clk_video) begin
        if (buf_wr.en) begin
            mem[buf_wr.addr] <= buf_wr.data;
        end
    end

    // ========================================
    // Registered read port
    // ========================================
    // One cycle from address to data
    always_ff @(posedge clk_video) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== hdl/osd_cmd_decoder.sv ====
`timescale 1ns/1ps

module osd_cmd_decoder import osd_pkg::*; (
    input  logic          clk_video,
    input  logic          rst_n,
    input  logic          cmd_frame,
    input  logic          cmd_valid,
    input  cmd_word_u     cmd_byte,
    output buf_wr_t       buf_wr,
    output logic          osd_enable,
    output logic [31:0]   status,
    output logic [15:0]   joystick_0,
    output logic [15:0]   joystick_1
);

    // Byte only counts inside an open frame
    logic take;

    decode_state_t state;
    logic [3:0]    line_num;
    logic [4:0]    char_cnt;

    // Buffer write port registers
    logic                      wr_en;
    logic [buf_addr_width-1:0] wr_addr;
    logic [7:0]                wr_data;

    assign take = cmd_valid & cmd_frame;

    // ========================================
    // Command state machine
    // ========================================
    always_ff @(posedge clk_video or negedge rst_n) begin
        if (!rst_n) begin
            state      <= idle;
            line_num   <= 4'd0;
            char_cnt   <= 5'd0;
            wr_en      <= 1'b0;
            osd_enable <= 1'b0;
            status     <= 32'd0;
            joystick_0 <= 16'd0;
            joystick_1 <= 16'd0;
        end else begin
            // Write strobe lasts one cycle
            wr_en <= 1'b0;

            if (take) begin
                case (state)
                    idle: begin
                        // Whole opcode first
                        case (cmd_byte.opcode)
                            cmd_osd_disable: osd_enable <= 1'b0;
                            cmd_osd_enable:  osd_enable <= 1'b1;
                            cmd_joystick_0:  state <= joy0_lo;
                            cmd_joystick_1:  state <= joy1_lo;
                            cmd_status:      state <= status_0;
                            default: begin
                                // Line write, lower nibble picks the row
                                if (cmd_byte.line.line_class == cmd_line_class) begin
                                    line_num <= cmd_byte.line.line_num;
                                    char_cnt <= 5'd0;
                                    state    <= line_data;
                                end
                                // Anything else is dropped
                            end
                        endcase
                    end

                    line_data: begin
                        wr_en    <= 1'b1;
                        char_cnt <= char_cnt + 5'd1;
                        // 32nd character closes the line
                        if (char_cnt == 5'd31) begin
                            state <= idle;
                        end
                    end

                    // Joystick words, low byte first
                    joy0_lo: begin
                        joystick_0[7:0] <= cmd_byte.opcode;
                        state           <= joy0_hi;
                    end
                    joy0_hi: begin
                        joystick_0[15:8] <= cmd_byte.opcode;
                        state            <= idle;
                    end
                    joy1_lo: begin
                        joystick_1[7:0] <= cmd_byte.opcode;
                        state           <= joy1_hi;
                    end
                    joy1_hi: begin
                        joystick_1[15:8] <= cmd_byte.opcode;
                        state            <= idle;
                    end

                    // Status word, four bytes from the bottom up
                    status_0: begin
                        status[7:0] <= cmd_byte.opcode;
                        state       <= status_1;
                    end
                    status_1: begin
                        status[15:8] <= cmd_byte.opcode;
                        state        <= status_2;
                    end
                    status_2: begin
                        status[23:16] <= cmd_byte.opcode;
                        state         <= status_3;
                    end
                    status_3: begin
                        status[31:24] <= cmd_byte.opcode;
                        state         <= idle;
                    end

                    default: state <= idle;
                endcase
            end

            // Closed frame drops any half-done command
            if (!cmd_frame) begin
                state <= idle;
            end
        end
    end

    // ========================================
    // Buffer write address and data
    // ========================================
    always_ff @(posedge clk_video) begin
        if (take && state == line_data) begin
            // Row times 32 plus column
            wr_addr <= {line_num, char_cnt};
            wr_data <= cmd_byte.opcode;
        end
    end

    assign buf_wr = '{en: wr_en, addr: wr_addr, data: wr_data};

endmodule

// ==== hdl/osd_glyph_renderer.sv ====
`timescale 1ns/1ps

module osd_glyph_renderer import osd_pkg::*; (
    input  logic                      clk_video,
    input  logic                      rst_n,
    input  logic                      osd_enable,
    input  logic [11:0]               pixel_x,
    input  logic [11:0]               pixel_y,
    input  logic [7:0]                rd_data,
    output logic [buf_addr_width-1:0] rd_addr,
    output logic                      osd_visible,
    output logic                      osd_pixel
);

    // Pixel position relative to the window corner
    logic [11:0] rel_x;
    logic [11:0] rel_y;
    logic        in_window;

    // Stage one registers
    logic        s1_visible;
    logic [2:0]  s1_row;
    logic [2:0]  s1_col;

    // Glyph rule result
    logic        lit;

    // ========================================
    // Stage one, window test and addressing
    // ========================================
    // Left of or above the corner wraps to a large value
    assign rel_x = pixel_x - osd_x_offset;
    assign rel_y = pixel_y - osd_y_offset;

    assign in_window = osd_enable && (rel_x < osd_width) && (rel_y < osd_height);

    // Character cell, row times 32 plus column
    assign rd_addr = {rel_y[6:3], rel_x[7:3]};

    always_ff @(posedge clk_video or negedge rst_n) begin
        if (!rst_n) begin
            s1_visible <= 1'b0;
        end else begin
            s1_visible <= in_window;
        end
    end

    // Pixel inside the cell
    always_ff @(posedge clk_video) begin
        s1_row <= rel_y[2:0];
        s1_col <= rel_x[2:0];
    end

    // ========================================
    // Stage two, glyph pixel
    // ========================================
    // Bit 7 is the leftmost column
    // Bottom row left dark as line spacing
    assign lit = (s1_row != 3'd7) && rd_data[3'd7 - s1_col];

    always_ff @(posedge clk_video or negedge rst_n) begin
        if (!rst_n) begin
            osd_visible <= 1'b0;
            osd_pixel   <= 1'b0;
        end else begin
            osd_visible <= s1_visible;
            osd_pixel   <= s1_visible & lit;
        end
    end

endmodule

// ==== hdl/osd_overlay_top.sv ====
`timescale 1ns/1ps

module osd_overlay_top import osd_pkg::*; (
    input  logic        clk_video,
    input  logic        rst_n,
    // Host command stream
    input  logic        cmd_frame,
    input  logic        cmd_valid,
    input  logic [7:0]  cmd_byte,
    // Video from the core
    input  logic [23:0] video_in,
    input  logic        de_in,
    input  logic        hs_in,
    input  logic        vs_in,
    input  logic [11:0] pixel_x,
    input  logic [11:0] pixel_y,
    // Video with overlay
    output logic [23:0] video_out,
    output logic        de_out,
    output logic        hs_out,
    output logic        vs_out,
    // Control registers
    output logic [31:0] status,
    output logic [15:0] joystick_0,
    output logic [15:0] joystick_1
);

    cmd_word_u                 cmd_word;
    buf_wr_t                   buf_wr;
    logic                      osd_enable;
    logic [buf_addr_width-1:0] rd_addr;
    logic [7:0]                rd_data;
    logic                      osd_visible;
    logic                      osd_pixel;
    video_bus_t                video_bus_in;
    video_bus_t                video_bus_out;

    // ========================================
    // Port packing
    // ========================================
    assign cmd_word     = cmd_byte;
    assign video_bus_in = '{rgb: video_in, de: de_in, hs: hs_in, vs: vs_in};

    assign video_out = video_bus_out.rgb;
    assign de_out    = video_bus_out.de;
    assign hs_out    = video_bus_out.hs;
    assign vs_out    = video_bus_out.vs;

    // ========================================
    // Blocks
    // ========================================
    osd_cmd_decoder osd_cmd_decoder_inst (
        .clk_video  (clk_video),
        .rst_n      (rst_n),
        .cmd_frame  (cmd_frame),
        .cmd_valid  (cmd_valid),
        .cmd_byte   (cmd_word),
        .buf_wr     (buf_wr),
        .osd_enable (osd_enable),
        .status     (status),
        .joystick_0 (joystick_0),
        .joystick_1 (joystick_1)
    );

    osd_char_buffer osd_char_buffer_inst (
        .clk_video (clk_video),
        .buf_wr    (buf_wr),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    // Two cycles from coordinates to glyph pixel
    osd_glyph_renderer osd_glyph_renderer_inst (
        .clk_video   (clk_video),
        .rst_n       (rst_n),
        .osd_enable  (osd_enable),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .rd_data     (rd_data),
        .rd_addr     (rd_addr),
        .osd_visible (osd_visible),
        .osd_pixel   (osd_pixel)
    );

    osd_video_mixer osd_video_mixer_inst (
        .clk_video   (clk_video),
        .rst_n       (rst_n),
        .video_in    (video_bus_in),
        .osd_visible (osd_visible),
        .osd_pixel   (osd_pixel),
        .video_out   (video_bus_out)
    );

endmodule

// ==== hdl/osd_pkg.sv ====
package osd_pkg;

    // ========================================
    // Host command codes
    // ========================================
    localparam logic [7:0] cmd_osd_disable = 8'h40;
    localparam logic [7:0] cmd_osd_enable  = 8'h41;
    localparam logic [7:0] cmd_joystick_0  = 8'h02;
    localparam logic [7:0] cmd_joystick_1  = 8'h03;
    localparam logic [7:0] cmd_status      = 8'h1E;
    // Upper nibble of 0x20..0x2F line writes
    localparam logic [3:0] cmd_line_class  = 4'h2;

    // ========================================
    // Window geometry
    // ========================================
    localparam int osd_cols   = 32;
    localparam int osd_rows   = 16;
    localparam int glyph_size = 8;

    // Window size in pixels, 256 x 128
    localparam logic [11:0] osd_width  = 12'(osd_cols * glyph_size);
    localparam logic [11:0] osd_height = 12'(osd_rows * glyph_size);

    // Top left corner, centred on 1024x768
    localparam logic [11:0] osd_x_offset = 12'd384;
    localparam logic [11:0] osd_y_offset = 12'd320;

    // ========================================
    // Buffer and colour
    // ========================================
    localparam int buf_addr_width = 9;
    localparam int buf_depth      = osd_cols * osd_rows;

    // Cyan foreground
    localparam logic [23:0] osd_fg_color = 24'h00FFFF;

    // ========================================
    // Types
    // ========================================
    // Host byte, seen as full opcode or as class plus line number
    typedef union packed {
        logic [7:0] opcode;
        struct packed {
            logic [3:0] line_class;
            logic [3:0] line_num;
        } line;
    } cmd_word_u;

    typedef struct packed {
        logic [23:0] rgb;
        logic        de;
        logic        hs;
        logic        vs;
    } video_bus_t;

    // Blanked video with syncs idle high
    localparam video_bus_t video_reset = '{rgb: 24'd0, de: 1'b0, hs: 1'b1, vs: 1'b1};

    typedef struct packed {
        logic                      en;
        logic [buf_addr_width-1:0] addr;
        logic [7:0]                data;
    } buf_wr_t;

    typedef enum logic [3:0] {
        idle,
        line_data,
        joy0_lo,
        joy0_hi,
        joy1_lo,
        joy1_hi,
        status_0,
        status_1,
        status_2,
        status_3
    } decode_state_t;

endpackage

// ==== hdl/osd_video_mixer.sv ====
`timescale 1ns/1ps

module osd_video_mixer import osd_pkg::*; (
    input  logic       clk_video,
    input  logic       rst_n,
    input  video_bus_t video_in,
    input  logic       osd_visible,
    input  logic       osd_pixel,
    output video_bus_t video_out
);

    // Two stage delay, matches the renderer
    video_bus_t video_d1;
    video_bus_t video_d2;

    // Video darkened to half, per channel
    logic [23:0] dim_rgb;

    // ========================================
    // Video delay line
    // ========================================
    always_ff @(posedge clk_video or negedge rst_n) begin
        if (!rst_n) begin
            video_d1 <= video_reset;
            video_d2 <= video_reset;
        end else begin
            video_d1 <= video_in;
            video_d2 <= video_d1;
        end
    end

    // Each 8-bit channel shifted right by one
    assign dim_rgb = {1'b0, video_d2.rgb[23:17],
                      1'b0, video_d2.rgb[15:9],
                      1'b0, video_d2.rgb[7:1]};

    // ========================================
    // Overlay blend and output register
    // ========================================
    always_ff @(posedge clk_video or negedge rst_n) begin
        if (!rst_n) begin
            video_out <= video_reset;
        end else begin
            // Syncs and enable unchanged
            video_out.de <= video_d2.de;
            video_out.hs <= video_d2.hs;
            video_out.vs <= video_d2.vs;

            if (osd_visible && osd_pixel) begin
                video_out.rgb <= osd_fg_color;
            end else if (osd_visible) begin
                video_out.rgb <= dim_rgb;
            end else begin
                video_out.rgb <= video_d2.rgb;
            end
        end
    end

endmodule

// ==== tests/osd_overlay_tb.sv ====
`timescale 1ns/1ps

module osd_overlay_tb import osd_pkg::*; ();

    // One pixel of model history before the blend
    typedef struct packed {
        video_bus_t v;
        logic       vis;
        logic       lit;
    } ref_entry_t;

    logic        clk_video = 1'b0;
    logic        rst_n;
    logic        cmd_frame;
    logic        cmd_valid;
    logic [7:0]  cmd_byte;
    logic [23:0] video_in = 24'd0;
    logic        de_in    = 1'b0;
    logic        hs_in    = 1'b1;
    logic        vs_in    = 1'b1;
    logic [11:0] pixel_x  = 12'd0;
    logic [11:0] pixel_y  = 12'd0;
    logic [23:0] video_out;
    logic        de_out;
    logic        hs_out;
    logic        vs_out;
    logic [31:0] status;
    logic [15:0] joystick_0;
    logic [15:0] joystick_1;

    // Coordinate source select
    // 0 parked, 1 random, 2 sweep over line 5
    logic [1:0]  scan_mode;
    logic [11:0] sweep_x = 12'd376;
    logic [11:0] sweep_y = 12'd360;

    // Mirror of decoder registers and character memory
    logic        model_en;
    logic [31:0] exp_status;
    logic [15:0] exp_joy0;
    logic [15:0] exp_joy1;
    logic [7:0]  char_mem [buf_depth];

    // Three deep history whose last stage is the expected output
    logic        model_live = 1'b0;
    video_bus_t  stim_video;
    ref_entry_t  hist0 = '0;
    ref_entry_t  hist1 = '0;
    video_bus_t  exp_video = video_reset;

    osd_overlay_top osd_overlay_top_inst (.*);

    always #50 clk_video = ~clk_video;

    // ========================================
    // Video and coordinate driver
    // ========================================
    always @(posedge clk_video) begin
        video_in <= 24'($urandom);
        de_in    <= 1'($urandom);
        hs_in    <= 1'($urandom);
        vs_in    <= 1'($urandom);
        case (scan_mode)
            2'd1: begin
                pixel_x <= 12'($urandom_range(1023));
                pixel_y <= 12'($urandom_range(767));
            end
            2'd2: begin
                pixel_x <= sweep_x;
                pixel_y <= sweep_y;
                // Eight pixels each side past the window edges
                if (sweep_x == 12'd647) begin
                    sweep_x <= 12'd376;
                    sweep_y <= (sweep_y == 12'd367) ? 12'd360 : sweep_y + 12'd1;
                end else begin
                    sweep_x <= sweep_x + 12'd1;
                end
            end
            default: begin
                pixel_x <= 12'd0;
                pixel_y <= 12'd0;
            end
        endcase
    end

    // ========================================
    // Reference model
    // ========================================
    assign stim_video = '{rgb: video_in, de: de_in, hs: hs_in, vs: vs_in};

    // Window test and glyph rule for one pixel
    function automatic ref_entry_t capture_pixel(input video_bus_t v, input logic [11:0] x,
                                                 input logic [11:0] y, input logic en);
        ref_entry_t e;
        int         dx;
        int         dy;
        logic [7:0] ch;
        e.v   = v;
        e.vis = en && (x >= osd_x_offset) && (x < osd_x_offset + osd_width)
                   && (y >= osd_y_offset) && (y < osd_y_offset + osd_height);
        e.lit = 1'b0;
        if (e.vis) begin
            dx = int'(x - osd_x_offset);
            dy = int'(y - osd_y_offset);
            ch = char_mem[9'(dy / glyph_size * osd_cols + dx / glyph_size)];
            // Bottom row of a cell stays dark
            e.lit = ((dy % glyph_size) != 7) && ch[3'(7 - dx % glyph_size)];
        end
        return e;
    endfunction

    function automatic video_bus_t blend_pixel(input ref_entry_t e);
        video_bus_t o;
        o = e.v;
        if (e.vis && e.lit) begin
            o.rgb = osd_fg_color;
        end else if (e.vis) begin
            o.rgb = {e.v.rgb[23:16] >> 1, e.v.rgb[15:8] >> 1, e.v.rgb[7:0] >> 1};
        end
        return o;
    endfunction

    always @(posedge clk_video) begin
        model_live <= 1'b1;
        if (!rst_n) begin
            hist0     <= '{v: video_reset, vis: 1'b0, lit: 1'b0};
            hist1     <= '{v: video_reset, vis: 1'b0, lit: 1'b0};
            exp_video <= video_reset;
        end else begin
            hist0     <= capture_pixel(stim_video, pixel_x, pixel_y, model_en);
            hist1     <= hist0;
            exp_video <= blend_pixel(hist1);
        end
    end

    // ========================================
    // Output checks on every edge after the first
    // ========================================
    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, want);
        $display("Simulation failed");
        $fatal(1, "Output check failed");
    endtask

    // Reset values come out of the model during reset
    a_video_out: assert property (@(posedge clk_video) model_live |-> video_out == exp_video.rgb)
        else report_mismatch("video_out", 32'($sampled(video_out)), 32'($sampled(exp_video.rgb)));
    a_de_out: assert property (@(posedge clk_video) model_live |-> de_out == exp_video.de)
        else report_mismatch("de_out", 32'($sampled(de_out)), 32'($sampled(exp_video.de)));
    a_hs_out: assert property (@(posedge clk_video) model_live |-> hs_out == exp_video.hs)
        else report_mismatch("hs_out", 32'($sampled(hs_out)), 32'($sampled(exp_video.hs)));
    a_vs_out: assert property (@(posedge clk_video) model_live |-> vs_out == exp_video.vs)
        else report_mismatch("vs_out", 32'($sampled(vs_out)), 32'($sampled(exp_video.vs)));
    a_status: assert property (@(posedge clk_video) model_live |-> status == exp_status)
        else report_mismatch("status", $sampled(status), $sampled(exp_status));
    a_joystick_0: assert property (@(posedge clk_video) model_live |-> joystick_0 == exp_joy0)
        else report_mismatch("joystick_0", 32'($sampled(joystick_0)), 32'($sampled(exp_joy0)));
    a_joystick_1: assert property (@(posedge clk_video) model_live |-> joystick_1 == exp_joy1)
        else report_mismatch("joystick_1", 32'($sampled(joystick_1)), 32'($sampled(exp_joy1)));

    // ========================================
    // Host command tasks
    // ========================================
    // Byte is taken on the edge this task returns on
    task automatic send_byte(input logic [7:0] b);
        @(posedge clk_video);
        cmd_frame <= 1'b1;
        cmd_valid <= 1'b1;
        cmd_byte  <= b;
        @(posedge clk_video);
        cmd_valid <= 1'b0;
    endtask

    task automatic end_frame();
        @(posedge clk_video);
        cmd_frame <= 1'b0;
    endtask

    task automatic set_osd(input logic on);
        send_byte(on ? cmd_osd_enable : cmd_osd_disable);
        model_en <= on;
        end_frame();
    endtask

    // Low byte first
    task automatic load_joystick(input logic sel, input logic [15:0] v);
        send_byte(sel ? cmd_joystick_1 : cmd_joystick_0);
        for (int i = 0; i < 2; i++) begin
            send_byte(v[8*i +: 8]);
            if (sel) begin
                exp_joy1[8*i +: 8] <= v[8*i +: 8];
            end else begin
                exp_joy0[8*i +: 8] <= v[8*i +: 8];
            end
        end
        end_frame();
    endtask

    // Fewer than four bytes leaves the load half done
    task automatic load_status_bytes(input logic [31:0] v, input int count);
        send_byte(cmd_status);
        for (int i = 0; i < count; i++) begin
            send_byte(v[8*i +: 8]);
            exp_status[8*i +: 8] <= v[8*i +: 8];
        end
        end_frame();
    endtask

    task automatic write_line(input logic [3:0] line);
        logic [7:0] c;
        send_byte({cmd_line_class, line});
        for (int i = 0; i < osd_cols; i++) begin
            c = 8'(i * 53 + 29);
            send_byte(c);
            char_mem[9'(int'(line) * osd_cols + i)] <= c;
        end
        end_frame();
    endtask

    task automatic release_reset();
        repeat (10) @(posedge clk_video);
        rst_n <= 1'b1;
    endtask

    task automatic set_scan(input logic [1:0] m);
        scan_mode <= m;
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        void'($urandom(32'h3ffa0b0b));
        rst_n      = 1'b0;
        cmd_frame  = 1'b0;
        cmd_valid  = 1'b0;
        cmd_byte   = 8'd0;
        scan_mode  = 2'd0;
        model_en   = 1'b0;
        exp_status = 32'd0;
        exp_joy0   = 16'd0;
        exp_joy1   = 16'd0;
        release_reset();

        // Passthrough with random coordinates that also land in the window
        set_scan(2'd1);
        repeat (300) @(posedge clk_video);

        load_joystick(1'b0, 16'($urandom));
        load_joystick(1'b1, 16'($urandom));
        load_status_bytes($urandom, 4);

        // Opcodes outside the command set
        send_byte(8'h55);
        send_byte(8'h3A);
        send_byte(8'h00);
        send_byte(8'hFF);
        end_frame();
        repeat (20) @(posedge clk_video);

        // Frame drops after two status bytes and the next frame starts fresh
        load_status_bytes(32'hA1B2C3D4, 2);
        load_joystick(1'b1, 16'h5AC3);

        // Overlay over line 5 including the window edges
        write_line(4'd5);
        set_scan(2'd2);
        set_osd(1'b1);
        repeat (2200) @(posedge clk_video);

        // Back to passthrough while the sweep goes on
        set_osd(1'b0);
        repeat (600) @(posedge clk_video);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule
